/* hw/dma_bus_pkg.sv */
`default_nettype none

package dma_bus_pkg;

    // full width word on the cpu bus and the dma master port
    typedef logic [31:0] bus_word_t;

    // byte address inside the dma target window
    typedef logic [23:0] dma_addr_t;

    // step, words per block and block count
    typedef logic [15:0] count_t;

    // one sample from the local source buffer
    typedef logic [15:0] half_t;

    // byte lane selects on the dma port
    typedef logic [3:0] byte_sel_t;

endpackage

`default_nettype wire

/* hw/dma_reg_pkg.sv */
`default_nettype none

package dma_reg_pkg;

    // word offset taken from bus address bits 4:2
    typedef logic [2:0] reg_off_t;

    localparam reg_off_t REG_ADDR   = 3'd0;
    localparam reg_off_t REG_STEP   = 3'd1;
    localparam reg_off_t REG_CYCLES = 3'd2;
    localparam reg_off_t REG_BLOCKS = 3'd3;
    localparam reg_off_t REG_START  = 3'd4;
    localparam reg_off_t REG_STOP   = 3'd5;
    localparam reg_off_t REG_STATUS = 3'd6;
    localparam reg_off_t REG_MATCH  = 3'd7;

    // bit positions in the status word
    localparam int ST_DONE  = 0;
    localparam int ST_BLOCK = 1;
    localparam int ST_MATCH = 2;

    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_ARMED,
        ENG_ISSUE,
        ENG_WAIT,
        ENG_GAP
    } eng_state_t;

endpackage

`default_nettype wire

/* hw/dma_cfg_if.sv */
`timescale 1ns/1ps
`default_nettype none

// register levels that hold until the cpu rewrites them
interface dma_cfg_if
    import dma_bus_pkg::*;
();

    dma_addr_t base;
    count_t    step;
    count_t    cycles;
    count_t    words;
    dma_addr_t match;

    // set by a REG_START write, cleared by REG_STOP
    logic      start;

    modport decode (
        output base, step, cycles, words, match, start
    );

    // engine and status side
    modport sink (
        input base, step, cycles, words, match, start
    );

endinterface

`default_nettype wire

/* hw/dma_evt_if.sv */
`timescale 1ns/1ps
`default_nettype none

// progress of the transfer engine
interface dma_evt_if
    import dma_bus_pkg::*;
();

    // single cycle pulses
    logic      seq_start;
    logic      block_start;
    logic      block_end;

    // only meaningful alongside block_end
    logic      last_block;

    dma_addr_t cur_addr;

    modport engine (
        output seq_start, block_start, block_end, last_block, cur_addr
    );

    modport status (
        input seq_start, block_start, block_end, last_block, cur_addr
    );

endinterface

`default_nettype wire

/* hw/dma_reg_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_reg_decode
    import dma_bus_pkg::*;
    import dma_reg_pkg::*;
#(
    parameter logic [7:0] ADDR = 8'h40
) (
    input  wire            wb_clk,
    input  wire            wb_rst,
    input  wire            wb_dbus_cyc,
    input  wire            wb_dbus_we,
    input  wire bus_word_t wb_dbus_adr,
    input  wire bus_word_t wb_dbus_dat,
    output logic           dbus_ack,
    output reg_off_t       reg_off,
    output logic           rd_en,
    dma_cfg_if.decode      cfg
);

    logic cs;
    logic ack_q;
    logic wr_en;

    // chip select on the top address byte
    assign cs = wb_dbus_cyc && (wb_dbus_adr[31:24] == ADDR);

    // write lands on the same edge that raises ack
    assign wr_en = cs && !ack_q && wb_dbus_we;

    assign reg_off  = wb_dbus_adr[4:2];
    assign dbus_ack = ack_q;
    assign rd_en    = ack_q && !wb_dbus_we;

    // ack never rises right after an ack so the master can drop cyc
    always_ff @(posedge wb_clk) begin
        if (wb_rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= cs && !ack_q;
        end
    end

    always_ff @(posedge wb_clk) begin
        if (wb_rst) begin
            cfg.base   <= '0;
            cfg.step   <= '0;
            cfg.cycles <= '0;
            cfg.words  <= '0;
            cfg.match  <= '0;
            cfg.start  <= 1'b0;
        end else if (wr_en) begin
            case (reg_off)
                REG_ADDR: begin
                    cfg.base <= wb_dbus_dat[23:0];
                end
                REG_STEP: begin
                    cfg.step <= wb_dbus_dat[15:0];
                end
                REG_CYCLES: begin
                    cfg.cycles <= wb_dbus_dat[15:0];
                end
                REG_BLOCKS: begin
                    cfg.words <= wb_dbus_dat[15:0];
                end
                // start and stop ignore the data word
                REG_START: begin
                    cfg.start <= 1'b1;
                end
                REG_STOP: begin
                    cfg.start <= 1'b0;
                end
                REG_MATCH: begin
                    cfg.match <= wb_dbus_dat[23:0];
                end
                default: begin
                    // status is read only
                end
            endcase
        end
    end

    // every cpu access gets a single ack pulse
    ack_single: assert property (
        @(posedge wb_clk) disable iff (wb_rst)
        dbus_ack |=> !dbus_ack
    );

endmodule

`default_nettype wire

/* hw/dma_xfer_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_xfer_engine
    import dma_bus_pkg::*;
    import dma_reg_pkg::*;
#(
    parameter int XFER_ADDR_W = 3
) (
    input  wire                    wb_clk,
    input  wire                    wb_rst,
    input  wire                    xfer_block,
    dma_cfg_if.sink                cfg,
    dma_evt_if.engine              evt,
    output logic                   dma_cyc,
    output logic                   dma_we,
    output byte_sel_t              dma_sel,
    output bus_word_t              dma_adr,
    output bus_word_t              dma_dat,
    input  wire                    dma_ack,
    output logic [XFER_ADDR_W-1:0] xfer_adr,
    output logic                   xfer_re,
    input  wire half_t             xfer_dat
);

    eng_state_t state;
    dma_addr_t  blk_base;
    dma_addr_t  addr;
    count_t     blocks_left;
    count_t     words_left;

    logic       seq_go;
    logic       blk_go;
    logic       word_ack;
    logic       last_word;
    bus_word_t  lane_dat;

    // zero extended word aligned bus address
    function automatic bus_word_t word_adr(input dma_addr_t a);
        return {8'h00, a[23:2], 2'b00};
    endfunction

    // half-word lane picked by address bit 1
    function automatic byte_sel_t word_sel(input dma_addr_t a);
        return a[1] ? 4'b1100 : 4'b0011;
    endfunction

    assign seq_go = (state == ENG_IDLE) && cfg.start;

    // blocks_left at zero in armed means the sequence is done
    assign blk_go = (state == ENG_ARMED) && cfg.start && xfer_block
                    && (blocks_left != '0) && (cfg.words != '0);

    assign word_ack  = dma_cyc && dma_ack && cfg.start;
    assign last_word = (words_left == 16'd1);

    assign lane_dat = addr[1] ? {xfer_dat, 16'h0000} : {16'h0000, xfer_dat};
    assign dma_dat  = word_ack ? lane_dat : '0;
    assign xfer_re  = word_ack;

    assign evt.seq_start   = seq_go;
    assign evt.block_start = blk_go;
    assign evt.block_end   = word_ack && last_word;
    assign evt.last_block  = (blocks_left == 16'd1);
    assign evt.cur_addr    = addr;

    always_ff @(posedge wb_clk) begin
        if (wb_rst) begin
            state       <= ENG_IDLE;
            blk_base    <= '0;
            addr        <= '0;
            blocks_left <= '0;
            words_left  <= '0;
            xfer_adr    <= '0;
            dma_cyc     <= 1'b0;
            dma_we      <= 1'b0;
            dma_sel     <= '0;
            dma_adr     <= '0;
        end else if (!cfg.start) begin
            // stop abandons any word in flight
            state   <= ENG_IDLE;
            addr    <= '0;
            dma_cyc <= 1'b0;
            dma_we  <= 1'b0;
            dma_sel <= '0;
            dma_adr <= '0;
        end else begin
            case (state)
                ENG_IDLE: begin
                    // snapshot so later writes need a restart
                    blk_base    <= cfg.base;
                    blocks_left <= cfg.cycles;
                    state       <= ENG_ARMED;
                end
                ENG_ARMED: begin
                    if (blk_go) begin
                        addr       <= blk_base;
                        words_left <= cfg.words;
                        xfer_adr   <= '0;
                        dma_cyc    <= 1'b1;
                        dma_we     <= 1'b1;
                        dma_sel    <= word_sel(blk_base);
                        dma_adr    <= word_adr(blk_base);
                        state      <= ENG_ISSUE;
                    end
                end
                ENG_ISSUE, ENG_WAIT: begin
                    if (word_ack) begin
                        dma_cyc    <= 1'b0;
                        dma_we     <= 1'b0;
                        dma_sel    <= '0;
                        dma_adr    <= '0;
                        xfer_adr   <= xfer_adr + XFER_ADDR_W'(1);
                        words_left <= words_left - 16'd1;
                        if (last_word) begin
                            // next block starts one half-word higher
                            blk_base    <= blk_base + 24'd2;
                            blocks_left <= blocks_left - 16'd1;
                            state       <= ENG_ARMED;
                        end else begin
                            addr  <= addr + dma_addr_t'(cfg.step);
                            state <= ENG_GAP;
                        end
                    end else begin
                        state <= ENG_WAIT;
                    end
                end
                ENG_GAP: begin
                    dma_cyc <= 1'b1;
                    dma_we  <= 1'b1;
                    dma_sel <= word_sel(addr);
                    dma_adr <= word_adr(addr);
                    state   <= ENG_ISSUE;
                end
                default: begin
                    state <= ENG_IDLE;
                end
            endcase
        end
    end

    // request frozen until the slave acks
    req_hold: assert property (
        @(posedge wb_clk) disable iff (wb_rst)
        dma_cyc && !dma_ack |=> !dma_cyc || ($stable(dma_adr) && $stable(dma_sel))
    );

    idle_quiet: assert property (
        @(posedge wb_clk) disable iff (wb_rst)
        state == ENG_IDLE |-> !dma_cyc
    );

endmodule

`default_nettype wire

/* hw/dma_status_read.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_status_read
    import dma_bus_pkg::*;
    import dma_reg_pkg::*;
(
    input  wire           wb_clk,
    input  wire           wb_rst,
    dma_evt_if.status     evt,
    dma_cfg_if.sink       cfg,
    input  wire reg_off_t reg_off,
    input  wire           rd_en,
    output bus_word_t     dbus_rdt,
    output logic          block_done,
    output logic          xfer_done,
    output logic          xfer_match
);

    logic      match_hit;
    bus_word_t status_word;
    bus_word_t rd_mux;

    // a zero match register disables the compare
    assign match_hit = (cfg.match != '0) && (evt.cur_addr == cfg.match);

    always_ff @(posedge wb_clk) begin
        if (wb_rst) begin
            block_done <= 1'b0;
            xfer_done  <= 1'b0;
        end else if (!cfg.start || evt.seq_start) begin
            block_done <= 1'b0;
            xfer_done  <= 1'b0;
        end else begin
            if (evt.block_start) begin
                block_done <= 1'b0;
            end
            if (evt.block_end) begin
                block_done <= 1'b1;
                if (evt.last_block) begin
                    xfer_done <= 1'b1;
                end
            end
        end
    end

    // sticky until start drops
    always_ff @(posedge wb_clk) begin
        if (wb_rst) begin
            xfer_match <= 1'b0;
        end else if (!cfg.start) begin
            xfer_match <= 1'b0;
        end else if (match_hit) begin
            xfer_match <= 1'b1;
        end
    end

    always_comb begin
        status_word           = '0;
        status_word[ST_DONE]  = xfer_done;
        status_word[ST_BLOCK] = block_done;
        status_word[ST_MATCH] = xfer_match;
    end

    always_comb begin
        case (reg_off)
            REG_ADDR:   rd_mux = {8'h00, cfg.base};
            REG_STEP:   rd_mux = {16'h0000, cfg.step};
            REG_CYCLES: rd_mux = {16'h0000, cfg.cycles};
            REG_BLOCKS: rd_mux = {16'h0000, cfg.words};
            REG_STATUS: rd_mux = status_word;
            REG_MATCH:  rd_mux = {8'h00, cfg.match};
            // start and stop are write only
            default:    rd_mux = '0;
        endcase
    end

    assign dbus_rdt = rd_en ? rd_mux : '0;

    // last block end also sets block_done
    done_order: assert property (
        @(posedge wb_clk) disable iff (wb_rst)
        xfer_done |-> block_done
    );

endmodule

`default_nettype wire

/* hw/dma_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_top
    import dma_bus_pkg::*;
    import dma_reg_pkg::*;
#(
    parameter logic [7:0] ADDR        = 8'h40,
    parameter int         XFER_ADDR_W = 3
) (
    input  wire                   wb_clk,
    input  wire                   wb_rst,

    // cpu bus
    input  wire                   wb_dbus_cyc,
    input  wire                   wb_dbus_we,
    input  wire bus_word_t        wb_dbus_adr,
    input  wire bus_word_t        wb_dbus_dat,
    output wire bus_word_t        dbus_rdt,
    output wire                   dbus_ack,

    // transfer control and flags
    input  wire                   xfer_block,
    output wire                   block_done,
    output wire                   xfer_done,
    output wire                   xfer_match,

    // source buffer
    output wire [XFER_ADDR_W-1:0] xfer_adr,
    output wire                   xfer_re,
    input  wire half_t            xfer_dat,

    // dma master, write only
    output wire                   dma_cyc,
    output wire                   dma_we,
    output wire byte_sel_t        dma_sel,
    output wire bus_word_t        dma_adr,
    output wire bus_word_t        dma_dat,
    input  wire                   dma_ack
);

    reg_off_t reg_off;
    logic     rd_en;

    dma_cfg_if cfg_bus ();
    dma_evt_if evt_bus ();

    dma_reg_decode #(
        .ADDR(ADDR)
    ) u_decode (
        .wb_clk      (wb_clk),
        .wb_rst      (wb_rst),
        .wb_dbus_cyc (wb_dbus_cyc),
        .wb_dbus_we  (wb_dbus_we),
        .wb_dbus_adr (wb_dbus_adr),
        .wb_dbus_dat (wb_dbus_dat),
        .dbus_ack    (dbus_ack),
        .reg_off     (reg_off),
        .rd_en       (rd_en),
        .cfg         (cfg_bus)
    );

    dma_xfer_engine #(
        .XFER_ADDR_W(XFER_ADDR_W)
    ) u_engine (
        .wb_clk     (wb_clk),
        .wb_rst     (wb_rst),
        .xfer_block (xfer_block),
        .cfg        (cfg_bus),
        .evt        (evt_bus),
        .dma_cyc    (dma_cyc),
        .dma_we     (dma_we),
        .dma_sel    (dma_sel),
        .dma_adr    (dma_adr),
        .dma_dat    (dma_dat),
        .dma_ack    (dma_ack),
        .xfer_adr   (xfer_adr),
        .xfer_re    (xfer_re),
        .xfer_dat   (xfer_dat)
    );

    dma_status_read u_status (
        .wb_clk     (wb_clk),
        .wb_rst     (wb_rst),
        .evt        (evt_bus),
        .cfg        (cfg_bus),
        .reg_off    (reg_off),
        .rd_en      (rd_en),
        .dbus_rdt   (dbus_rdt),
        .block_done (block_done),
        .xfer_done  (xfer_done),
        .xfer_match (xfer_match)
    );

endmodule

`default_nettype wire

/* sim/tb_dma.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dma
    import dma_reg_pkg::*;
;

    localparam logic [7:0] CHIP = 8'h40;
    localparam int         AW   = 3;

    logic          wb_clk = 1'b0;
    logic          wb_rst;
    logic          wb_dbus_cyc;
    logic          wb_dbus_we;
    logic [31:0]   wb_dbus_adr;
    logic [31:0]   wb_dbus_dat;
    wire  [31:0]   dbus_rdt;
    wire           dbus_ack;
    logic          xfer_block;
    wire           block_done;
    wire           xfer_done;
    wire           xfer_match;
    wire  [AW-1:0] xfer_adr;
    wire           xfer_re;
    wire  [15:0]   xfer_dat;
    wire           dma_cyc;
    wire           dma_we;
    wire  [3:0]    dma_sel;
    wire  [31:0]   dma_adr;
    wire  [31:0]   dma_dat;
    logic          dma_ack = 1'b0;

    integer        seed;
    integer        errors;
    integer        checks;
    integer        rd_ptr;
    integer        lat = 0;
    logic          lat_run = 1'b0;
    integer        re_count = 0;

    // one entry per acked write on the dma port
    logic [31:0]   rec_adr[$];
    logic [3:0]    rec_sel[$];
    logic [31:0]   rec_dat[$];
    logic          rec_we[$];

    dma_top #(
        .ADDR        (CHIP),
        .XFER_ADDR_W (AW)
    ) u_dut (
        .wb_clk      (wb_clk),
        .wb_rst      (wb_rst),
        .wb_dbus_cyc (wb_dbus_cyc),
        .wb_dbus_we  (wb_dbus_we),
        .wb_dbus_adr (wb_dbus_adr),
        .wb_dbus_dat (wb_dbus_dat),
        .dbus_rdt    (dbus_rdt),
        .dbus_ack    (dbus_ack),
        .xfer_block  (xfer_block),
        .block_done  (block_done),
        .xfer_done   (xfer_done),
        .xfer_match  (xfer_match),
        .xfer_adr    (xfer_adr),
        .xfer_re     (xfer_re),
        .xfer_dat    (xfer_dat),
        .dma_cyc     (dma_cyc),
        .dma_we      (dma_we),
        .dma_sel     (dma_sel),
        .dma_adr     (dma_adr),
        .dma_dat     (dma_dat),
        .dma_ack     (dma_ack)
    );

    always #20 wb_clk = ~wb_clk;

    // source buffer model
    assign xfer_dat = 16'hA500 + {13'd0, xfer_adr};

    // slave model that acks after 0 to 4 extra cycles
    always @(negedge wb_clk) begin
        if (wb_rst || dma_ack || !dma_cyc) begin
            dma_ack = 1'b0;
            lat_run = 1'b0;
        end else begin
            if (!lat_run) begin
                lat     = (($random(seed) % 5) + 5) % 5;
                lat_run = 1'b1;
            end
            if (lat == 0) begin
                dma_ack = 1'b1;
                lat_run = 1'b0;
            end else begin
                lat = lat - 1;
            end
        end
    end

    always @(posedge wb_clk) begin
        if (!wb_rst && dma_cyc && dma_ack) begin
            rec_adr.push_back(dma_adr);
            rec_sel.push_back(dma_sel);
            rec_dat.push_back(dma_dat);
            rec_we.push_back(dma_we);
        end
        if (!wb_rst && xfer_re) begin
            re_count = re_count + 1;
        end
    end

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            $display("[FAIL] %0d ns: %s is 0x%h, expected 0x%h", $time, name, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic bus_write(input logic [2:0] off, input logic [31:0] data);
        int n;
        @(negedge wb_clk);
        wb_dbus_cyc = 1'b1;
        wb_dbus_we  = 1'b1;
        wb_dbus_adr = {CHIP, 19'd0, off, 2'b00};
        wb_dbus_dat = data;
        n = 0;
        @(negedge wb_clk);
        while (!dbus_ack && n < 20) begin
            @(negedge wb_clk);
            n = n + 1;
        end
        if (!dbus_ack) begin
            $display("bus write to offset %0d was never acked", off);
            errors = errors + 1;
        end
        wb_dbus_cyc = 1'b0;
        wb_dbus_we  = 1'b0;
    endtask

    task automatic bus_read(input logic [2:0] off, output logic [31:0] data);
        int n;
        @(negedge wb_clk);
        wb_dbus_cyc = 1'b1;
        wb_dbus_we  = 1'b0;
        wb_dbus_adr = {CHIP, 19'd0, off, 2'b00};
        n = 0;
        @(negedge wb_clk);
        while (!dbus_ack && n < 20) begin
            @(negedge wb_clk);
            n = n + 1;
        end
        data = dbus_rdt;
        if (!dbus_ack) begin
            $display("bus read of offset %0d was never acked", off);
            errors = errors + 1;
        end
        wb_dbus_cyc = 1'b0;
    endtask

    task automatic program_regs(input logic [23:0] base, input logic [15:0] step,
                                input logic [15:0] cycles, input logic [15:0] words,
                                input logic [23:0] match);
        bus_write(REG_ADDR, {8'h00, base});
        bus_write(REG_STEP, {16'h0000, step});
        bus_write(REG_CYCLES, {16'h0000, cycles});
        bus_write(REG_BLOCKS, {16'h0000, words});
        bus_write(REG_MATCH, {8'h00, match});
        bus_write(REG_START, 32'd1);
    endtask

    task automatic stop_engine();
        bus_write(REG_STOP, 32'd0);
        // flags clear one cycle after start drops
        repeat (2) @(negedge wb_clk);
        expect_eq("block_done after stop", 32'(block_done), 32'd0);
        expect_eq("xfer_done after stop", 32'(xfer_done), 32'd0);
        expect_eq("xfer_match after stop", 32'(xfer_match), 32'd0);
    endtask

    task automatic pulse_block();
        @(negedge wb_clk);
        xfer_block = 1'b1;
        @(negedge wb_clk);
        xfer_block = 1'b0;
    endtask

    task automatic wait_block_done();
        int n;
        n = 0;
        while (!block_done && n < 400) begin
            @(negedge wb_clk);
            n = n + 1;
        end
        if (!block_done) begin
            $display("block_done did not rise within %0d cycles", n);
            errors = errors + 1;
        end
    endtask

    // expected word at base + 2k + i*step carries sample i
    task automatic check_word(input int k, input int i, input logic [23:0] base,
                              input logic [15:0] step);
        logic [23:0] a;
        logic [15:0] sample;
        logic [31:0] exp_adr;
        logic [3:0]  exp_sel;
        logic [31:0] exp_dat;
        if (rd_ptr >= rec_adr.size()) begin
            $display("block %0d word %0d never reached the dma port", k, i);
            errors = errors + 1;
        end else begin
            a       = base + 24'(2 * k) + 24'(i) * 24'(step);
            sample  = 16'hA500 + 16'(i);
            exp_adr = {8'h00, a[23:2], 2'b00};
            exp_sel = a[1] ? 4'b1100 : 4'b0011;
            exp_dat = a[1] ? {sample, 16'h0000} : {16'h0000, sample};
            expect_eq("dma_adr", rec_adr[rd_ptr], exp_adr);
            expect_eq("dma_sel", 32'(rec_sel[rd_ptr]), 32'(exp_sel));
            expect_eq("dma_dat", rec_dat[rd_ptr], exp_dat);
            expect_eq("dma_we", 32'(rec_we[rd_ptr]), 32'd1);
            rd_ptr = rd_ptr + 1;
        end
    endtask

    task automatic run_block(input int k, input logic [23:0] base, input logic [15:0] step,
                             input int words, input logic last);
        int first_re;
        first_re = re_count;
        pulse_block();
        wait_block_done();
        expect_eq("block_done", 32'(block_done), 32'd1);
        expect_eq("xfer_done", 32'(xfer_done), 32'(last));
        expect_eq("word count", 32'(rec_adr.size() - rd_ptr), 32'(words));
        expect_eq("xfer_re count", 32'(re_count - first_re), 32'(words));
        for (int i = 0; i < words; i++) begin
            check_word(k, i, base, step);
        end
        rd_ptr = rec_adr.size();
    endtask

    task automatic reset_defaults();
        logic [31:0] d;
        expect_eq("dbus_ack", 32'(dbus_ack), 32'd0);
        expect_eq("dma_cyc", 32'(dma_cyc), 32'd0);
        expect_eq("dma_we", 32'(dma_we), 32'd0);
        expect_eq("dma_sel", 32'(dma_sel), 32'd0);
        expect_eq("xfer_re", 32'(xfer_re), 32'd0);
        expect_eq("block_done", 32'(block_done), 32'd0);
        expect_eq("xfer_done", 32'(xfer_done), 32'd0);
        expect_eq("xfer_match", 32'(xfer_match), 32'd0);
        for (int r = 0; r < 8; r++) begin
            bus_read(3'(r), d);
            expect_eq("register after reset", d, 32'd0);
        end
    endtask

    task automatic register_access();
        logic [31:0] d;
        bus_write(REG_ADDR, 32'hFFAB_CDEF);
        bus_read(REG_ADDR, d);
        expect_eq("base register", d, 32'h00AB_CDEF);
        bus_write(REG_STEP, 32'h1234_5678);
        bus_read(REG_STEP, d);
        expect_eq("step register", d, 32'h0000_5678);
        bus_write(REG_CYCLES, 32'hDEAD_0003);
        bus_read(REG_CYCLES, d);
        expect_eq("block count register", d, 32'h0000_0003);
        bus_write(REG_BLOCKS, 32'hBEEF_0021);
        bus_read(REG_BLOCKS, d);
        expect_eq("word count register", d, 32'h0000_0021);
        bus_write(REG_MATCH, 32'h12FE_DCBA);
        bus_read(REG_MATCH, d);
        expect_eq("match register", d, 32'h00FE_DCBA);
        bus_read(REG_START, d);
        expect_eq("start offset", d, 32'd0);
        bus_read(REG_STOP, d);
        expect_eq("stop offset", d, 32'd0);
        // status is read only
        bus_write(REG_STATUS, 32'hFFFF_FFFF);
        bus_read(REG_STATUS, d);
        expect_eq("status register", d, 32'd0);
        // the ignored status write leaves the other registers alone
        bus_read(REG_ADDR, d);
        expect_eq("base after status write", d, 32'h00AB_CDEF);
        bus_read(REG_STEP, d);
        expect_eq("step after status write", d, 32'h0000_5678);
        bus_read(REG_CYCLES, d);
        expect_eq("block count after status write", d, 32'h0000_0003);
        bus_read(REG_BLOCKS, d);
        expect_eq("word count after status write", d, 32'h0000_0021);
        bus_read(REG_MATCH, d);
        expect_eq("match after status write", d, 32'h00FE_DCBA);
    endtask

    task automatic single_block();
        program_regs(24'h000100, 16'd2, 16'd1, 16'd4, 24'h0);
        run_block(0, 24'h000100, 16'd2, 4, 1'b1);
        stop_engine();
    endtask

    task automatic strided_blocks();
        int n0;
        program_regs(24'h000200, 16'd4, 16'd3, 16'd3, 24'h0);
        for (int k = 0; k < 3; k++) begin
            run_block(k, 24'h000200, 16'd4, 3, k == 2);
        end
        // a further pulse after the last block moves nothing
        n0 = rec_adr.size();
        pulse_block();
        repeat (20) @(negedge wb_clk);
        expect_eq("writes after done", 32'(rec_adr.size() - n0), 32'd0);
        expect_eq("xfer_done after extra pulse", 32'(xfer_done), 32'd1);
        rd_ptr = rec_adr.size();
        stop_engine();
    endtask

    task automatic random_ack_latency();
        // addresses wrap past the top of the 24-bit space
        program_regs(24'hFFFFF8, 16'd6, 16'd2, 16'd5, 24'h0);
        run_block(0, 24'hFFFFF8, 16'd6, 5, 1'b0);
        run_block(1, 24'hFFFFF8, 16'd6, 5, 1'b1);
        stop_engine();
    endtask

    task automatic address_match();
        logic [31:0] d;
        program_regs(24'h000400, 16'd2, 16'd1, 16'd4, 24'h000404);
        run_block(0, 24'h000400, 16'd2, 4, 1'b1);
        expect_eq("xfer_match on hit", 32'(xfer_match), 32'd1);
        bus_read(REG_STATUS, d);
        expect_eq("status on hit", d, 32'h0000_0007);
        stop_engine();
        program_regs(24'h000400, 16'd2, 16'd1, 16'd4, 24'h0);
        run_block(0, 24'h000400, 16'd2, 4, 1'b1);
        expect_eq("xfer_match with zero match", 32'(xfer_match), 32'd0);
        bus_read(REG_STATUS, d);
        expect_eq("status with zero match", d, 32'h0000_0003);
        stop_engine();
        program_regs(24'h000400, 16'd2, 16'd1, 16'd4, 24'h000500);
        run_block(0, 24'h000400, 16'd2, 4, 1'b1);
        expect_eq("xfer_match on miss", 32'(xfer_match), 32'd0);
        bus_read(REG_STATUS, d);
        expect_eq("status on miss", d, 32'h0000_0003);
        stop_engine();
    endtask

    task automatic stop_and_restart();
        int n;
        program_regs(24'h000600, 16'd2, 16'd2, 16'd6, 24'h000600);
        run_block(0, 24'h000600, 16'd2, 6, 1'b0);
        expect_eq("xfer_match before stop", 32'(xfer_match), 32'd1);
        pulse_block();
        n = 0;
        while (rec_adr.size() - rd_ptr < 2 && n < 400) begin
            @(negedge wb_clk);
            n = n + 1;
        end
        if (rec_adr.size() - rd_ptr < 2) begin
            $display("second block did not write two words before the stop");
            errors = errors + 1;
        end
        stop_engine();
        check_word(1, 0, 24'h000600, 16'd2);
        check_word(1, 1, 24'h000600, 16'd2);
        // skip a word in flight at the stop that may show up once
        rd_ptr = rec_adr.size();
        pulse_block();
        for (int c = 0; c < 20; c++) begin
            @(negedge wb_clk);
            expect_eq("dma_cyc while stopped", 32'(dma_cyc), 32'd0);
        end
        expect_eq("writes while stopped", 32'(rec_adr.size() - rd_ptr), 32'd0);
        bus_write(REG_START, 32'd1);
        run_block(0, 24'h000600, 16'd2, 6, 1'b0);
        stop_engine();
    endtask

    initial begin
        seed        = 32'h08b6_f7af;
        errors      = 0;
        checks      = 0;
        rd_ptr      = 0;
        wb_rst      = 1'b1;
        wb_dbus_cyc = 1'b0;
        wb_dbus_we  = 1'b0;
        wb_dbus_adr = 32'd0;
        wb_dbus_dat = 32'd0;
        xfer_block  = 1'b0;
        repeat (3) @(posedge wb_clk);
        @(negedge wb_clk);
        wb_rst = 1'b0;

        reset_defaults();
        register_access();
        single_block();
        strided_blocks();
        random_ack_latency();
        address_match();
        stop_and_restart();

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
hw/dma_bus_pkg.sv
hw/dma_reg_pkg.sv
hw/dma_cfg_if.sv
hw/dma_evt_if.sv
hw/dma_reg_decode.sv
hw/dma_xfer_engine.sv
hw/dma_status_read.sv
hw/dma_top.sv
sim/tb_dma.sv

/* run_sim.sh */
#!/bin/sh
# build and run tb_dma with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_dma -f compile.f; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_dma)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi

echo "simulation reported failures"
exit 1
